/* list.f */
i2c_master_pkg.sv
i2c_host_regs.sv
i2c_byte_ctrl.sv
i2c_bit_ctrl.sv
i2c_line_monitor.sv
i2c_master_top.sv
tb_i2c_slave.sv
tb_i2c_master.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_i2c_master
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

/* tb_i2c_master.sv */
`timescale 1ns/1ps

module tb_i2c_master;

	// register map and bits, kept local to the testbench
	localparam logic [2:0] A_PRER_LO = 3'd0;
	localparam logic [2:0] A_PRER_HI = 3'd1;
	localparam logic [2:0] A_CTR     = 3'd2;
	localparam logic [2:0] A_TXR     = 3'd3;
	localparam logic [2:0] A_CR      = 3'd4;
	localparam logic [7:0] CR_STA    = 8'h80;
	localparam logic [7:0] CR_STO    = 8'h40;
	localparam logic [7:0] CR_RD     = 8'h20;
	localparam logic [7:0] CR_WR     = 8'h10;
	localparam logic [7:0] CR_ACK    = 8'h08;
	localparam logic [7:0] CR_IACK   = 8'h01;
	localparam logic [7:0] CTR_EN    = 8'h80;
	localparam logic [7:0] CTR_IEN   = 8'h40;
	localparam logic [6:0] SLAVE_ADDR = 7'h3a;
	localparam logic [6:0] OTHER_ADDR = 7'h21; // nobody answers
	localparam int BUS_TIMEOUT = 20;           // cycles
	localparam int POLL_LIMIT  = 200;          // status reads

	logic       clk;
	logic       nReset;
	logic [2:0] adr;
	logic [7:0] dat_w;
	logic       we;
	logic       stb;
	logic       cyc;
	logic [7:0] dat_r;
	logic       ack;
	logic       inta;
	logic       scl_oen;
	logic       sda_oen;
	logic       slave_scl_pull;
	logic       slave_sda_pull;
	logic [7:0] slave_wr_byte;
	logic [7:0] slave_rd_byte;
	logic       scl_line;
	logic       sda_line;
	logic [31:0] lfsr_q;
	logic       allow_start;  // start/stop commanded right now
	logic       allow_stop;
	logic       checking;
	int         errors;
	int         test_errs;
	int         proto_errs;
	int         pass_cnt;
	int         fail_cnt;

	// open drain, low if either side pulls
	assign scl_line = scl_oen & ~slave_scl_pull;
	assign sda_line = sda_oen & ~slave_sda_pull;

	i2c_master_top uut (
		.clk          (clk),
		.nReset       (nReset),
		.adr_i        (adr),
		.dat_i        (dat_w),
		.we_i         (we),
		.stb_i        (stb),
		.cyc_i        (cyc),
		.dat_o        (dat_r),
		.ack_o        (ack),
		.inta_o       (inta),
		.scl_pad_i    (scl_line),
		.sda_pad_i    (sda_line),
		.scl_padoen_o (scl_oen),
		.sda_padoen_o (sda_oen)
	);

	tb_i2c_slave #(.ADDR(SLAVE_ADDR), .STRETCH(12)) slave (
		.clk        (clk),
		.scl_i      (scl_line),
		.sda_i      (sda_line),
		.rd_byte_i  (slave_rd_byte),
		.scl_pull_o (slave_scl_pull),
		.sda_pull_o (slave_sda_pull),
		.wr_byte_o  (slave_wr_byte)
	);

	always #50 clk = ~clk; // 100 ns period

	// sda may only move with scl high for a commanded start or stop
	always @(sda_line)
		if (checking && scl_line === 1'b1)
		begin
			if (sda_line === 1'b0)
				assert (allow_start) else
				begin
					$display("SDA fell while SCL high without a START command at %0t", $time);
					proto_errs++;
				end
			else
				assert (allow_stop) else
				begin
					$display("SDA rose while SCL high without a STOP command at %0t", $time);
					proto_errs++;
				end
		end

	// 32 bit fibonacci, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_byte(output logic [7:0] b);
		b = 8'h00;
		for (int i = 0; i < 8; i++)
		begin
			lfsr_q = lfsr_next(lfsr_q); // one step per bit
			b      = {b[6:0], lfsr_q[0]};
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s at %0t", why, $time);
		$display("Test failures found");
		$finish;
	endtask

	task automatic bus_write(input logic [2:0] a, input logic [7:0] d);
		int waited;
		waited = 0;
		@(negedge clk);
		adr   = a;
		dat_w = d;
		we    = 1'b1;
		stb   = 1'b1;
		cyc   = 1'b1;
		@(negedge clk);
		while (!ack && waited < BUS_TIMEOUT)
		begin
			@(negedge clk);
			waited++;
		end
		if (!ack)
			abort_run("bus write was never acknowledged");
		we  = 1'b0;
		stb = 1'b0;
		cyc = 1'b0;
	endtask

	task automatic bus_read(input logic [2:0] a, output logic [7:0] d);
		int waited;
		waited = 0;
		@(negedge clk);
		adr = a;
		we  = 1'b0;
		stb = 1'b1;
		cyc = 1'b1;
		@(negedge clk);
		while (!ack && waited < BUS_TIMEOUT)
		begin
			@(negedge clk);
			waited++;
		end
		if (!ack)
			abort_run("bus read was never acknowledged");
		d   = dat_r; // valid in the ack cycle
		stb = 1'b0;
		cyc = 1'b0;
	endtask

	// issue a command, clear the old flag, poll until done
	task automatic run_cmd(input logic [7:0] cmd);
		logic [7:0] sr;
		int         polls;
		polls       = 0;
		allow_start = cmd[7];
		allow_stop  = cmd[6];
		bus_write(A_CR, cmd | CR_IACK);
		bus_read(A_CR, sr);
		// byte transfers keep tip up far longer than one status read
		if ((cmd & (CR_RD | CR_WR)) != 8'h00)
			expect_bits("tip during transfer", {7'b0, sr[1]}, 8'h01);
		while (!(sr[0] && !sr[1]) && polls < POLL_LIMIT)
		begin
			bus_read(A_CR, sr);
			polls++;
		end
		if (!(sr[0] && !sr[1]))
			abort_run("I2C command did not complete");
		allow_start = 1'b0;
		allow_stop  = 1'b0;
	endtask

	task automatic expect_bits(input string what, input logic [7:0] got,
		input logic [7:0] exp);
		assert (got === exp) else
		begin
			$display("MISMATCH at %0t: %s got %02h expected %02h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic close_test(input string name);
		if (errors == test_errs)
		begin
			pass_cnt++;
			$display("%s: pass", name);
		end
		else
		begin
			fail_cnt++;
			$display("%s: FAIL, %0d errors", name, errors - test_errs);
		end
		test_errs = errors;
	endtask

	initial
	begin : main_seq
		logic [7:0] rd;
		logic [7:0] b;
		clk           = 1'b0;
		nReset        = 1'b0;
		adr           = 3'd0;
		dat_w         = 8'h00;
		we            = 1'b0;
		stb           = 1'b0;
		cyc           = 1'b0;
		slave_rd_byte = 8'h00;
		lfsr_q        = 32'd74234;
		allow_start   = 1'b0;
		allow_stop    = 1'b0;
		checking      = 1'b0;
		errors        = 0;
		test_errs     = 0;
		proto_errs    = 0;
		pass_cnt      = 0;
		fail_cnt      = 0;
		repeat (2) @(negedge clk);
		nReset   = 1'b1;
		checking = 1'b1;

		// reset values, register readback
		bus_read(A_PRER_LO, rd);
		expect_bits("prescale lo after reset", rd, 8'hff);
		bus_read(A_PRER_HI, rd);
		expect_bits("prescale hi after reset", rd, 8'hff);
		bus_read(A_CTR, rd);
		expect_bits("control after reset", rd, 8'h00);
		bus_read(A_CR, rd);
		expect_bits("status after reset", rd, 8'h00);
		expect_bits("inta after reset", {7'b0, inta}, 8'h00);
		bus_write(A_PRER_LO, 8'h02); // short scl period
		bus_write(A_PRER_HI, 8'h00);
		bus_read(A_PRER_LO, rd);
		expect_bits("prescale lo readback", rd, 8'h02);
		bus_read(A_PRER_HI, rd);
		expect_bits("prescale hi readback", rd, 8'h00);
		bus_write(A_CTR, CTR_EN | CTR_IEN);
		bus_read(A_CTR, rd);
		expect_bits("control readback", rd, CTR_EN | CTR_IEN);
		bus_write(A_CTR, CTR_EN);
		for (int a = 5; a < 8; a++)
		begin
			bus_read(a[2:0], rd);
			expect_bits("unmapped address", rd, 8'h00);
		end
		close_test("test 1 reset and registers");

		// address write, then data with stop
		bus_write(A_TXR, {SLAVE_ADDR, 1'b0});
		run_cmd(CR_STA | CR_WR);
		bus_read(A_CR, rd);
		expect_bits("rxack after address", {7'b0, rd[7]}, 8'h00);
		expect_bits("busy after start", {7'b0, rd[6]}, 8'h01);
		random_byte(b);
		bus_write(A_TXR, b);
		run_cmd(CR_WR | CR_STO);
		bus_read(A_CR, rd);
		expect_bits("rxack after data", {7'b0, rd[7]}, 8'h00);
		expect_bits("busy after stop", {7'b0, rd[6]}, 8'h00);
		expect_bits("byte stored in slave", slave_wr_byte, b);
		close_test("test 2 write");

		// read one byte, nack it, stop
		random_byte(b);
		slave_rd_byte = b;
		bus_write(A_TXR, {SLAVE_ADDR, 1'b1});
		run_cmd(CR_STA | CR_WR);
		bus_read(A_CR, rd);
		expect_bits("rxack after read address", {7'b0, rd[7]}, 8'h00);
		run_cmd(CR_RD | CR_ACK | CR_STO);
		bus_read(A_TXR, rd);
		expect_bits("received byte", rd, b);
		close_test("test 3 read");

		// nobody at this address
		bus_write(A_TXR, {OTHER_ADDR, 1'b0});
		run_cmd(CR_STA | CR_WR);
		bus_read(A_CR, rd);
		expect_bits("rxack for unknown address", {7'b0, rd[7]}, 8'h01);
		run_cmd(CR_STO);
		bus_read(A_CR, rd);
		expect_bits("busy after stop", {7'b0, rd[6]}, 8'h00);
		close_test("test 4 not acknowledged");

		// interrupt output
		bus_write(A_CTR, CTR_EN | CTR_IEN);
		bus_write(A_TXR, {SLAVE_ADDR, 1'b0});
		run_cmd(CR_STA | CR_WR);
		expect_bits("inta with ien set", {7'b0, inta}, 8'h01);
		bus_write(A_CR, CR_IACK);
		bus_read(A_CR, rd);
		expect_bits("flag after iack", {7'b0, rd[0]}, 8'h00);
		expect_bits("inta after iack", {7'b0, inta}, 8'h00);
		bus_write(A_CTR, CTR_EN);
		run_cmd(CR_STO);
		bus_read(A_CR, rd);
		expect_bits("flag with ien clear", {7'b0, rd[0]}, 8'h01);
		expect_bits("inta with ien clear", {7'b0, inta}, 8'h00);
		close_test("test 5 interrupt");

		// line rules held over every transfer above, stretched acks too
		assert (proto_errs == 0) else
		begin
			$display("SDA changed %0d times with SCL high outside START or STOP", proto_errs);
			errors++;
		end
		close_test("test 6 protocol with stretching");

		$display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* tb_i2c_slave.sv */
`timescale 1ns/1ps

module tb_i2c_slave #(
	parameter logic [6:0] ADDR    = 7'h3a,
	parameter int         STRETCH = 12      // clocks scl is held after each ack
) (
	input  logic       clk,
	input  logic       scl_i,
	input  logic       sda_i,
	input  logic [7:0] rd_byte_i,            // returned on master reads
	output logic       scl_pull_o,
	output logic       sda_pull_o,
	output logic [7:0] wr_byte_o             // last byte written to us
);

	typedef enum logic [1:0] {
		SL_IDLE,
		SL_ADDR,
		SL_WDATA,
		SL_RDATA
	} slave_state_e;

	slave_state_e state = SL_IDLE;
	logic [7:0]   shreg = 8'h00;   // incoming bits
	logic [7:0]   tx_q = 8'h00;    // outgoing bits, msb on the line
	logic [7:0]   stored = 8'h00;
	logic         scl_prev = 1'b1;
	logic         sda_prev = 1'b1;
	logic         skip_fall = 1'b0; // scl fall that belongs to the start
	logic         matched = 1'b0;
	logic         rw = 1'b0;
	logic         mst_nack = 1'b0;
	logic         sda_pull = 1'b0;
	logic         scl_pull = 1'b0;
	int           bitcnt = 0;      // 0..7 data, 8 ack slot
	int           ack_ends = 0;    // counts finished ack slots
	int           ack_seen = 0;
	int           hold = 0;

	// one block watches both lines, so edge order is explicit
	always @(scl_i or sda_i)
	begin
		if (scl_i === 1'b1 && scl_prev === 1'b1 && sda_i !== sda_prev)
		begin
			if (sda_i === 1'b0)
			begin
				state     = SL_ADDR; // start or repeated start
				bitcnt    = 0;
				skip_fall = 1'b1;
			end
			else
				state = SL_IDLE; // stop
			sda_pull = 1'b0;
		end
		else if (scl_i === 1'b1 && scl_prev === 1'b0 && state != SL_IDLE)
		begin
			if (bitcnt < 8 && state != SL_RDATA)
				shreg = {shreg[6:0], sda_i};
			if (bitcnt == 8 && state == SL_RDATA)
				mst_nack = sda_i; // master's ack level
		end
		else if (scl_i === 1'b0 && scl_prev === 1'b1 && state != SL_IDLE)
		begin
			if (skip_fall)
				skip_fall = 1'b0;
			else if (bitcnt < 7)
			begin
				bitcnt = bitcnt + 1;
				if (state == SL_RDATA)
				begin
					tx_q     = {tx_q[6:0], 1'b0};
					sda_pull = ~tx_q[7];
				end
			end
			else if (bitcnt == 7)
			begin
				bitcnt = 8; // into the ack slot
				case (state)
					SL_ADDR:
					begin
						matched  = (shreg[7:1] == ADDR);
						rw       = shreg[0];
						sda_pull = matched; // ack only our address
					end
					SL_WDATA:
					begin
						stored   = shreg;
						sda_pull = 1'b1;
					end
					default: sda_pull = 1'b0; // master acks reads
				endcase
			end
			else
			begin
				bitcnt   = 0;
				ack_ends = ack_ends + 1; // starts a stretch
				sda_pull = 1'b0;
				if (state == SL_ADDR && !matched)
					state = SL_IDLE;
				else if (state == SL_ADDR && rw)
				begin
					state    = SL_RDATA;
					tx_q     = rd_byte_i;
					sda_pull = ~tx_q[7];
				end
				else if (state == SL_ADDR)
					state = SL_WDATA;
				else if (state == SL_RDATA && !mst_nack)
				begin
					tx_q     = rd_byte_i; // master wants more
					sda_pull = ~tx_q[7];
				end
				else if (state == SL_RDATA)
					state = SL_IDLE;
			end
		end
		scl_prev = scl_i;
		sda_prev = sda_i;
	end

	// clock stretching after every ack slot
	always @(negedge clk)
	begin
		if (ack_ends != ack_seen)
		begin
			ack_seen = ack_ends;
			hold     = STRETCH;
		end
		if (hold != 0)
		begin
			scl_pull = 1'b1;
			hold     = hold - 1;
		end
		else
			scl_pull = 1'b0;
	end

	assign scl_pull_o = scl_pull;
	assign sda_pull_o = sda_pull;
	assign wr_byte_o  = stored;

endmodule

/* i2c_master_top.sv */
`timescale 1ns/1ps

module i2c_master_top (
	input  logic                      clk,
	input  logic                      nReset,
	input  i2c_master_pkg::reg_addr_t adr_i,
	input  i2c_master_pkg::byte_t     dat_i,
	input  logic                      we_i,
	input  logic                      stb_i,
	input  logic                      cyc_i,
	output i2c_master_pkg::byte_t     dat_o,
	output logic                      ack_o,
	output logic                      inta_o,
	input  logic                      scl_pad_i,
	input  logic                      sda_pad_i,
	output logic                      scl_padoen_o,
	output logic                      sda_padoen_o
);
	import i2c_master_pkg::*;

	prescale_t prescale;
	byte_t     tx_byte;
	byte_t     rx_byte;
	bit_cmd_e  bit_cmd;
	logic      core_en;
	logic      start;
	logic      stop;
	logic      read;
	logic      write;
	logic      ack_in;
	logic      cmd_done;  // byte level finished
	logic      rx_ack;
	logic      busy;
	logic      tx_bit;
	logic      bit_done;  // bit level finished
	logic      scl_sync;
	logic      rx_bit;

	i2c_host_regs u_regs (
		.clk        (clk),
		.nReset     (nReset),
		.adr_i      (adr_i),
		.dat_i      (dat_i),
		.we_i       (we_i),
		.stb_i      (stb_i),
		.cyc_i      (cyc_i),
		.cmd_done_i (cmd_done),
		.rx_byte_i  (rx_byte),
		.rx_ack_i   (rx_ack),
		.busy_i     (busy),
		.dat_o      (dat_o),
		.ack_o      (ack_o),
		.inta_o     (inta_o),
		.prescale_o (prescale),
		.core_en_o  (core_en),
		.start_o    (start),
		.stop_o     (stop),
		.read_o     (read),
		.write_o    (write),
		.ack_in_o   (ack_in),
		.tx_byte_o  (tx_byte)
	);

	i2c_byte_ctrl u_byte (
		.clk        (clk),
		.nReset     (nReset),
		.start_i    (start),
		.stop_i     (stop),
		.read_i     (read),
		.write_i    (write),
		.ack_in_i   (ack_in),
		.tx_byte_i  (tx_byte),
		.bit_done_i (bit_done),
		.rx_bit_i   (rx_bit),
		.bit_cmd_o  (bit_cmd),
		.tx_bit_o   (tx_bit),
		.cmd_done_o (cmd_done),
		.rx_byte_o  (rx_byte),
		.rx_ack_o   (rx_ack)
	);

	i2c_bit_ctrl u_bit (
		.clk        (clk),
		.nReset     (nReset),
		.core_en_i  (core_en),
		.prescale_i (prescale),
		.bit_cmd_i  (bit_cmd),
		.tx_bit_i   (tx_bit),
		.scl_sync_i (scl_sync),
		.bit_done_o (bit_done),
		.scl_oen_o  (scl_padoen_o),
		.sda_oen_o  (sda_padoen_o)
	);

	// pads come in raw, monitor owns the synchronizers
	i2c_line_monitor u_mon (
		.clk        (clk),
		.nReset     (nReset),
		.scl_i      (scl_pad_i),
		.sda_i      (sda_pad_i),
		.scl_sync_o (scl_sync),
		.rx_bit_o   (rx_bit),
		.busy_o     (busy)
	);

endmodule

/* i2c_line_monitor.sv */
`timescale 1ns/1ps

module i2c_line_monitor (
	input  logic clk,
	input  logic nReset,
	input  logic scl_i,
	input  logic sda_i,
	output logic scl_sync_o,
	output logic rx_bit_o,
	output logic busy_o
);

	logic scl_meta;
	logic sda_meta;
	logic scl_s;     // synchronized
	logic sda_s;
	logic scl_d;     // one cycle older, for edges
	logic sda_d;
	logic sta_det;
	logic sto_det;

	// two flops per line, idle bus is high
	always_ff @(posedge clk or negedge nReset)
		if (!nReset)
		begin
			scl_meta <= 1'b1;
			sda_meta <= 1'b1;
			scl_s    <= 1'b1;
			sda_s    <= 1'b1;
			scl_d    <= 1'b1;
			sda_d    <= 1'b1;
		end
		else
		begin
			scl_meta <= scl_i;
			sda_meta <= sda_i;
			scl_s    <= scl_meta;
			sda_s    <= sda_meta;
			scl_d    <= scl_s;
			sda_d    <= sda_s;
		end

	always_ff @(posedge clk or negedge nReset)
		if (!nReset)
		begin
			sta_det  <= 1'b0;
			sto_det  <= 1'b0;
			busy_o   <= 1'b0;
			rx_bit_o <= 1'b0;
		end
		else
		begin
			sta_det <= ~sda_s & sda_d & scl_s; // sda falls, scl high
			sto_det <= sda_s & ~sda_d & scl_s; // sda rises, scl high
			busy_o  <= (sta_det | busy_o) & ~sto_det;
			if (scl_s & ~scl_d)
				rx_bit_o <= sda_s; // sample on scl rise
		end

	assign scl_sync_o = scl_s;

endmodule

/* i2c_bit_ctrl.sv */
`timescale 1ns/1ps

module i2c_bit_ctrl (
	input  logic                      clk,
	input  logic                      nReset,
	input  logic                      core_en_i,
	input  i2c_master_pkg::prescale_t prescale_i,
	input  i2c_master_pkg::bit_cmd_e  bit_cmd_i,
	input  logic                      tx_bit_i,
	input  logic                      scl_sync_i,
	output logic                      bit_done_o,
	output logic                      scl_oen_o,
	output logic                      sda_oen_o
);
	import i2c_master_pkg::*;

	typedef enum logic [4:0] {
		ST_IDLE,
		ST_START_A, ST_START_B, ST_START_C, ST_START_D, ST_START_E,
		ST_STOP_A, ST_STOP_B, ST_STOP_C, ST_STOP_D,
		ST_RD_A, ST_RD_B, ST_RD_C, ST_RD_D,
		ST_WR_A, ST_WR_B, ST_WR_C, ST_WR_D
	} bit_state_e;

	bit_state_e state_q;
	prescale_t  cnt_q;      // phase counter
	logic       clk_en;     // one phase step
	logic       dscl_oen;   // scl_oen one cycle late, lines up with sync delay
	logic       slave_wait;

	// we let scl go but it still reads low, slave is stretching
	assign slave_wait = dscl_oen & ~scl_sync_i;

	always_ff @(posedge clk or negedge nReset)
		if (!nReset)
			dscl_oen <= 1'b0;
		else
			dscl_oen <= scl_oen_o;

	always_ff @(posedge clk or negedge nReset)
		if (!nReset)
		begin
			cnt_q  <= '0;
			clk_en <= 1'b1;
		end
		else if (cnt_q == '0 || !core_en_i)
		begin
			if (slave_wait)
				clk_en <= 1'b0; // freeze at zero
			else
			begin
				cnt_q  <= prescale_i;
				clk_en <= 1'b1;
			end
		end
		else
		begin
			cnt_q  <= cnt_q - 16'd1;
			clk_en <= 1'b0;
		end

	always_ff @(posedge clk or negedge nReset)
		if (!nReset)
		begin
			state_q    <= ST_IDLE;
			bit_done_o <= 1'b0;
			scl_oen_o  <= 1'b1; // lines released
			sda_oen_o  <= 1'b1;
		end
		else
		begin
			bit_done_o <= 1'b0;
			if (clk_en)
				case (state_q)
					ST_IDLE:
						case (bit_cmd_i) // lines keep their level
							BIT_START: state_q <= ST_START_A;
							BIT_STOP:  state_q <= ST_STOP_A;
							BIT_WRITE: state_q <= ST_WR_A;
							BIT_READ:  state_q <= ST_RD_A;
							default:   state_q <= ST_IDLE;
						endcase
					ST_START_A:
					begin
						state_q   <= ST_START_B;
						sda_oen_o <= 1'b1; // sda up, scl unchanged
					end
					ST_START_B:
					begin
						state_q   <= ST_START_C;
						scl_oen_o <= 1'b1;
					end
					ST_START_C:
					begin
						state_q   <= ST_START_D;
						sda_oen_o <= 1'b0; // start condition
					end
					ST_START_D: state_q <= ST_START_E; // hold time
					ST_START_E:
					begin
						state_q    <= ST_IDLE;
						scl_oen_o  <= 1'b0;
						bit_done_o <= 1'b1;
					end
					ST_STOP_A:
					begin
						state_q   <= ST_STOP_B;
						scl_oen_o <= 1'b0;
						sda_oen_o <= 1'b0; // sda low while scl low
					end
					ST_STOP_B:
					begin
						state_q   <= ST_STOP_C;
						scl_oen_o <= 1'b1;
					end
					ST_STOP_C: state_q <= ST_STOP_D;
					ST_STOP_D:
					begin
						state_q    <= ST_IDLE;
						sda_oen_o  <= 1'b1; // stop condition
						bit_done_o <= 1'b1;
					end
					ST_RD_A:
					begin
						state_q   <= ST_RD_B;
						scl_oen_o <= 1'b0;
						sda_oen_o <= 1'b1; // slave drives sda
					end
					ST_RD_B:
					begin
						state_q   <= ST_RD_C;
						scl_oen_o <= 1'b1;
					end
					ST_RD_C: state_q <= ST_RD_D;
					ST_RD_D:
					begin
						state_q    <= ST_IDLE;
						scl_oen_o  <= 1'b0;
						bit_done_o <= 1'b1;
					end
					ST_WR_A:
					begin
						state_q   <= ST_WR_B;
						scl_oen_o <= 1'b0;
						sda_oen_o <= tx_bit_i; // change data with scl low
					end
					ST_WR_B:
					begin
						state_q   <= ST_WR_C;
						scl_oen_o <= 1'b1;
					end
					ST_WR_C: state_q <= ST_WR_D;
					ST_WR_D:
					begin
						state_q    <= ST_IDLE;
						scl_oen_o  <= 1'b0;
						bit_done_o <= 1'b1;
					end
					default: state_q <= ST_IDLE;
				endcase
		end

endmodule

/* i2c_byte_ctrl.sv */
`timescale 1ns/1ps

module i2c_byte_ctrl (
	input  logic                     clk,
	input  logic                     nReset,
	input  logic                     start_i,
	input  logic                     stop_i,
	input  logic                     read_i,
	input  logic                     write_i,
	input  logic                     ack_in_i,
	input  i2c_master_pkg::byte_t    tx_byte_i,
	input  logic                     bit_done_i,
	input  logic                     rx_bit_i,
	output i2c_master_pkg::bit_cmd_e bit_cmd_o,
	output logic                     tx_bit_o,
	output logic                     cmd_done_o,
	output i2c_master_pkg::byte_t    rx_byte_o,
	output logic                     rx_ack_o
);
	import i2c_master_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_START,
		ST_WRITE,
		ST_READ,
		ST_ACK,
		ST_STOP
	} byte_state_e;

	byte_state_e state_q;
	byte_t       sr_q;    // shift register, msb first
	logic [2:0]  dcnt_q;  // bits left in this byte
	logic        go;
	logic        ld;
	logic        shift;
	logic        cnt_done;

	// start alone does nothing, it rides along with read/write
	assign go       = (read_i | write_i | stop_i) & ~cmd_done_o;
	assign ld       = (state_q == ST_IDLE && go) || (state_q == ST_START && bit_done_i);
	assign shift    = (state_q == ST_WRITE || state_q == ST_READ) && bit_done_i;
	assign cnt_done = (dcnt_q == 3'd0);

	// in the ack slot we drive the host's ack level, else the next data bit
	assign tx_bit_o  = (state_q == ST_ACK) ? ack_in_i : sr_q[7];
	assign rx_byte_o = sr_q;

	always_ff @(posedge clk)
		if (ld)
			sr_q <= tx_byte_i;
		else if (shift)
			sr_q <= {sr_q[6:0], rx_bit_i}; // bus value comes back in

	always_ff @(posedge clk or negedge nReset)
		if (!nReset)
			dcnt_q <= 3'd0;
		else if (ld)
			dcnt_q <= 3'd7;
		else if (shift)
			dcnt_q <= dcnt_q - 3'd1;

	always_ff @(posedge clk or negedge nReset)
		if (!nReset)
		begin
			state_q    <= ST_IDLE;
			bit_cmd_o  <= BIT_NOP;
			cmd_done_o <= 1'b0;
			rx_ack_o   <= 1'b0;
		end
		else
		begin
			cmd_done_o <= 1'b0; // pulse
			case (state_q)
				ST_IDLE:
					if (go)
					begin
						if (start_i)
						begin
							state_q   <= ST_START;
							bit_cmd_o <= BIT_START;
						end
						else if (read_i)
						begin
							state_q   <= ST_READ;
							bit_cmd_o <= BIT_READ;
						end
						else if (write_i)
						begin
							state_q   <= ST_WRITE;
							bit_cmd_o <= BIT_WRITE;
						end
						else
						begin
							state_q   <= ST_STOP; // stop only
							bit_cmd_o <= BIT_STOP;
						end
					end
				ST_START:
					if (bit_done_i)
					begin
						state_q   <= read_i ? ST_READ : ST_WRITE;
						bit_cmd_o <= read_i ? BIT_READ : BIT_WRITE;
					end
				ST_WRITE:
					if (bit_done_i)
					begin
						state_q   <= cnt_done ? ST_ACK : ST_WRITE;
						bit_cmd_o <= cnt_done ? BIT_READ : BIT_WRITE; // read slave ack
					end
				ST_READ:
					if (bit_done_i)
					begin
						state_q   <= cnt_done ? ST_ACK : ST_READ;
						bit_cmd_o <= cnt_done ? BIT_WRITE : BIT_READ; // send our ack
					end
				ST_ACK:
					if (bit_done_i)
					begin
						rx_ack_o <= rx_bit_i; // last sampled bit is the ack
						if (stop_i)
						begin
							state_q   <= ST_STOP;
							bit_cmd_o <= BIT_STOP;
						end
						else
						begin
							state_q    <= ST_IDLE;
							bit_cmd_o  <= BIT_NOP;
							cmd_done_o <= 1'b1;
						end
					end
				ST_STOP:
					if (bit_done_i)
					begin
						state_q    <= ST_IDLE;
						bit_cmd_o  <= BIT_NOP;
						cmd_done_o <= 1'b1;
					end
				default:
					state_q <= ST_IDLE;
			endcase
		end

endmodule

/* i2c_host_regs.sv */
`timescale 1ns/1ps

module i2c_host_regs (
	input  logic                      clk,
	input  logic                      nReset,
	input  i2c_master_pkg::reg_addr_t adr_i,
	input  i2c_master_pkg::byte_t     dat_i,
	input  logic                      we_i,
	input  logic                      stb_i,
	input  logic                      cyc_i,
	input  logic                      cmd_done_i,
	input  i2c_master_pkg::byte_t     rx_byte_i,
	input  logic                      rx_ack_i,
	input  logic                      busy_i,
	output i2c_master_pkg::byte_t     dat_o,
	output logic                      ack_o,
	output logic                      inta_o,
	output i2c_master_pkg::prescale_t prescale_o,
	output logic                      core_en_o,
	output logic                      start_o,
	output logic                      stop_o,
	output logic                      read_o,
	output logic                      write_o,
	output logic                      ack_in_o,
	output i2c_master_pkg::byte_t     tx_byte_o
);
	import i2c_master_pkg::*;

	prescale_t prer_q;  // prescale register
	byte_t     ctr_q;   // control
	byte_t     txr_q;   // byte to send
	byte_t     status;  // assembled status byte
	logic      sta_q;
	logic      sto_q;
	logic      rd_q;
	logic      wr_q;
	logic      ack_q;   // ack level for reads
	logic      iack_q;  // self clearing
	logic      rxack_q;
	logic      tip_q;
	logic      irq_q;
	logic      wacc;

	assign wacc = cyc_i & stb_i & we_i & ~ack_o; // one write per bus cycle

	// single cycle ack, never back to back
	always_ff @(posedge clk or negedge nReset)
		if (!nReset)
			ack_o <= 1'b0;
		else
			ack_o <= cyc_i & stb_i & ~ack_o;

	// read mux, valid together with ack_o
	always_ff @(posedge clk)
		case (adr_i)
			ADDR_PRER_LO: dat_o <= prer_q[7:0];
			ADDR_PRER_HI: dat_o <= prer_q[15:8];
			ADDR_CTR:     dat_o <= ctr_q;
			ADDR_TXR_RXR: dat_o <= rx_byte_i;
			ADDR_CR_SR:   dat_o <= status;
			default:      dat_o <= '0; // txr/cr not readable
		endcase

	always_ff @(posedge clk or negedge nReset)
		if (!nReset)
		begin
			prer_q <= PRER_RESET;
			ctr_q  <= '0;
		end
		else if (wacc)
		begin
			if (adr_i == ADDR_PRER_LO)
				prer_q[7:0] <= dat_i;
			if (adr_i == ADDR_PRER_HI)
				prer_q[15:8] <= dat_i;
			if (adr_i == ADDR_CTR)
				ctr_q <= dat_i;
		end

	always_ff @(posedge clk)
		if (wacc && adr_i == ADDR_TXR_RXR)
			txr_q <= dat_i;

	// command bits, only accepted with the core enabled
	always_ff @(posedge clk or negedge nReset)
		if (!nReset)
		begin
			sta_q  <= 1'b0;
			sto_q  <= 1'b0;
			rd_q   <= 1'b0;
			wr_q   <= 1'b0;
			ack_q  <= 1'b0;
			iack_q <= 1'b0;
		end
		else if (wacc && adr_i == ADDR_CR_SR && ctr_q[CTR_EN_BIT])
		begin
			sta_q  <= dat_i[CR_STA_BIT];
			sto_q  <= dat_i[CR_STO_BIT];
			rd_q   <= dat_i[CR_RD_BIT];
			wr_q   <= dat_i[CR_WR_BIT];
			ack_q  <= dat_i[CR_ACK_BIT];
			iack_q <= dat_i[CR_IACK_BIT];
		end
		else
		begin
			if (cmd_done_i)
			begin
				sta_q <= 1'b0; // command finished
				sto_q <= 1'b0;
				rd_q  <= 1'b0;
				wr_q  <= 1'b0;
			end
			iack_q <= 1'b0; // one cycle only
		end

	always_ff @(posedge clk or negedge nReset)
		if (!nReset)
		begin
			rxack_q <= 1'b0;
			tip_q   <= 1'b0;
			irq_q   <= 1'b0;
			inta_o  <= 1'b0;
		end
		else
		begin
			rxack_q <= rx_ack_i;
			tip_q   <= rd_q | wr_q;
			irq_q   <= (cmd_done_i | irq_q) & ~iack_q; // sticky until acked
			inta_o  <= irq_q & ctr_q[CTR_IEN_BIT];
		end

	always_comb
	begin
		status               = '0; // unused bits read zero
		status[SR_RXACK_BIT] = rxack_q;
		status[SR_BUSY_BIT]  = busy_i;
		status[SR_TIP_BIT]   = tip_q;
		status[SR_IF_BIT]    = irq_q;
	end

	assign prescale_o = prer_q;
	assign core_en_o  = ctr_q[CTR_EN_BIT];
	assign start_o    = sta_q;
	assign stop_o     = sto_q;
	assign read_o     = rd_q;
	assign write_o    = wr_q;
	assign ack_in_o   = ack_q;
	assign tx_byte_o  = txr_q;

endmodule

/* i2c_master_pkg.sv */
package i2c_master_pkg;

	// bus widths
	localparam int unsigned PRER_W = 16;
	localparam int unsigned BYTE_W = 8;
	localparam int unsigned ADDR_W = 3;

	typedef logic [PRER_W-1:0] prescale_t; // clocks per quarter scl period, minus one
	typedef logic [BYTE_W-1:0] byte_t;     // one data byte
	typedef logic [ADDR_W-1:0] reg_addr_t; // host register address

	// host register map
	localparam reg_addr_t ADDR_PRER_LO = 3'd0;
	localparam reg_addr_t ADDR_PRER_HI = 3'd1;
	localparam reg_addr_t ADDR_CTR     = 3'd2;
	localparam reg_addr_t ADDR_TXR_RXR = 3'd3; // write txr, read rxr
	localparam reg_addr_t ADDR_CR_SR   = 3'd4; // write cr, read sr

	localparam prescale_t PRER_RESET = 16'hffff; // slowest scl out of reset

	// control register
	localparam int unsigned CTR_EN_BIT  = 7; // core enable
	localparam int unsigned CTR_IEN_BIT = 6; // interrupt enable

	// command register
	localparam int unsigned CR_STA_BIT  = 7; // generate (repeated) start
	localparam int unsigned CR_STO_BIT  = 6; // generate stop
	localparam int unsigned CR_RD_BIT   = 5; // read byte
	localparam int unsigned CR_WR_BIT   = 4; // write byte
	localparam int unsigned CR_ACK_BIT  = 3; // ack level sent after a read
	localparam int unsigned CR_IACK_BIT = 0; // clear pending interrupt

	// status register
	localparam int unsigned SR_RXACK_BIT = 7; // ack from slave, 0 = acked
	localparam int unsigned SR_BUSY_BIT  = 6; // start seen, no stop yet
	localparam int unsigned SR_TIP_BIT   = 1; // transfer in progress
	localparam int unsigned SR_IF_BIT    = 0; // interrupt flag

	// commands from byte level to bit level, one-hot
	typedef enum logic [3:0] {
		BIT_NOP   = 4'b0000,
		BIT_START = 4'b0001,
		BIT_STOP  = 4'b0010,
		BIT_WRITE = 4'b0100,
		BIT_READ  = 4'b1000
	} bit_cmd_e;

endpackage
